// ==== Makefile ====
TOP := tb_tqv_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv --timescale 1ns/1ps -f tqv_periph.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== hw/bus_decode.sv ====
// Decode stage that splits the core address into slot selects and blocks repeat reads
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defs.svh"

module bus_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  tqv_periph_pkg::bus_addr_t i_addr,
    input  tqv_periph_pkg::word_t     i_wdata,
    input  tqv_periph_pkg::xfer_n_t   i_write_n,
    input  tqv_periph_pkg::xfer_n_t   i_read_n,
    input  logic                      i_read_block,
    periph_bus_if.decoder             bus
);
    import tqv_periph_pkg::*;

    slot_t user_slot;
    slot_t simple_slot;
    logic  byte_side;
    logic  rd_served;   // Read answered and core still holding the code

    assign byte_side   = i_addr[10];
    assign user_slot   = i_addr[9:6];
    assign simple_slot = i_addr[7:4];

    always_comb begin
        for (int s = 0; s < `TQV_USER_SLOTS; s++) begin
            bus.user_sel[s] = !byte_side && (user_slot == slot_t'(s));
        end
        for (int s = 0; s < `TQV_SIMPLE_SLOTS; s++) begin
            bus.simple_sel[s] = byte_side && (simple_slot == slot_t'(s));
        end
    end

    // Stays set until the core drops its read request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_served <= 1'b0;
        end else begin
            rd_served <= (i_read_block || rd_served) && (i_read_n != `TQV_XFER_IDLE);
        end
    end

    assign bus.offset = i_addr[5:0];   // Byte slots only look at the low nibble
    assign bus.wdata  = i_wdata;
    assign bus.wr_n   = i_write_n;

    // Peripherals must not see the same read twice
    assign bus.rd_n = (i_read_block || rd_served) ? `TQV_XFER_IDLE : i_read_n;

endmodule

`default_nettype wire

// ==== hw/byte_scratch.sv ====
// Byte-slot scratch peripheral with four byte registers
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defs.svh"

module byte_scratch (
    input  logic                  clk,
    input  logic                  rst_n,
    periph_bus_if.target          bus,
    output tqv_periph_pkg::byte_t o_rdata,
    output tqv_periph_pkg::pins_t o_pins
);
    import tqv_periph_pkg::*;

    localparam int NUM_REGS = 4;

    byte_t      regs [NUM_REGS];
    logic       wr_en;
    logic       reg_hit;   // Offsets 0..3 of the 16-byte slot
    logic [1:0] idx;

    assign wr_en   = bus.simple_sel[`TQV_SIMPLE_SCRATCH] && (bus.wr_n != `TQV_XFER_IDLE);
    assign reg_hit = (bus.offset[3:2] == 2'b00);
    assign idx     = bus.offset[1:0];

    // Any write size lands the low byte
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en && reg_hit) begin
            regs[idx] <= bus.wdata[7:0];
        end
    end

    assign o_rdata = reg_hit ? regs[idx] : '0;
    assign o_pins  = regs[0];

endmodule

`default_nettype wire

// ==== hw/gpio_ctrl.sv ====
// GPIO block with output register, input readback and per-pin output function routing
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defs.svh"

module gpio_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    periph_bus_if.target          bus,
    input  tqv_periph_pkg::pins_t i_ui_in,
    input  tqv_periph_pkg::pins_t i_scratch_pins,
    input  tqv_periph_pkg::pins_t i_byte_pins,
    output tqv_periph_pkg::word_t o_rdata,
    output tqv_periph_pkg::pins_t o_pins
);
    import tqv_periph_pkg::*;

    pins_t     gpio_out;
    func_sel_t func_sel [`TQV_NUM_PINS];
    logic      wr_en;
    logic      sel_hit;                               // Offset is in the select block
    logic [$clog2(`TQV_NUM_PINS)-1:0] sel_idx;

    assign wr_en   = bus.user_sel[`TQV_SLOT_GPIO] && (bus.wr_n != `TQV_XFER_IDLE);
    assign sel_hit = (bus.offset >= `TQV_GPIO_SEL_BASE) && (bus.offset[1:0] == 2'b00);
    assign sel_idx = bus.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && (bus.offset == `TQV_GPIO_OUT_OFS)) begin
            gpio_out <= bus.wdata[`TQV_NUM_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `TQV_NUM_PINS; p++) begin
                func_sel[p] <= func_sel_t'(`TQV_SLOT_GPIO);   // All pins start on GPIO
            end
        end else if (wr_en && sel_hit) begin
            func_sel[sel_idx] <= bus.wdata[4:0];
        end
    end

    // Register readback
    always_comb begin
        if (bus.offset == `TQV_GPIO_OUT_OFS) begin
            o_rdata = word_t'(gpio_out);
        end else if (bus.offset == `TQV_GPIO_IN_OFS) begin
            o_rdata = word_t'(i_ui_in);
        end else if (sel_hit) begin
            o_rdata = word_t'(func_sel[sel_idx]);
        end else begin
            o_rdata = '0;
        end
    end

    // Each pin takes its own bit from the slot its select names
    always_comb begin
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            if (func_sel[p][4]) begin
                o_pins[p] = (func_sel[p][3:0] == slot_t'(`TQV_SIMPLE_SCRATCH)) && i_byte_pins[p];
            end else if (func_sel[p][3:0] == slot_t'(`TQV_SLOT_GPIO)) begin
                o_pins[p] = gpio_out[p];
            end else if (func_sel[p][3:0] == slot_t'(`TQV_SLOT_SCRATCH)) begin
                o_pins[p] = i_scratch_pins[p];
            end else begin
                o_pins[p] = 1'b0;   // Unmapped slot
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/periph_bus_if.sv ====
// Decoded peripheral bus between the decode stage, the peripherals and the read return
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
    import tqv_periph_pkg::*;

    slot_vec_t user_sel;    // One-hot full slot select
    slot_vec_t simple_sel;  // One-hot byte slot select
    offset_t   offset;
    word_t     wdata;
    xfer_n_t   wr_n;
    xfer_n_t   rd_n;        // Forced idle while a read result is pending

    modport decoder (
        output user_sel, simple_sel, offset, wdata, wr_n, rd_n
    );

    modport target (
        input user_sel, simple_sel, offset, wdata, wr_n, rd_n
    );

    // Read return only needs to know which slot answers
    modport monitor (
        input user_sel, simple_sel
    );

endinterface

`default_nettype wire

// ==== hw/read_return.sv ====
// Read return stage with the slot read mux, data hold until read complete and ready
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defs.svh"

module read_return (
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.monitor           bus,
    input  tqv_periph_pkg::xfer_n_t i_read_n,
    input  tqv_periph_pkg::xfer_n_t i_write_n,
    input  logic                    i_read_complete,
    input  tqv_periph_pkg::word_t   i_gpio_rdata,
    input  tqv_periph_pkg::word_t   i_scratch_rdata,
    input  logic                    i_scratch_rdy,
    input  tqv_periph_pkg::byte_t   i_byte_rdata,
    output tqv_periph_pkg::word_t   o_rdata,
    output logic                    o_ready,
    output logic                    o_read_block
);
    import tqv_periph_pkg::*;

    word_t peri_data;
    logic  peri_rdy;
    word_t rdata_q;
    logic  hold_q;    // Result captured and not yet consumed
    logic  ready_q;
    logic  read_req;

    assign read_req = (i_read_n != `TQV_XFER_IDLE);

    // Byte slots, GPIO and unmapped full slots answer at once
    always_comb begin
        peri_data = '0;
        peri_rdy  = 1'b1;
        if (bus.simple_sel[`TQV_SIMPLE_SCRATCH]) begin
            peri_data = word_t'(i_byte_rdata);
        end else if (bus.user_sel[`TQV_SLOT_GPIO]) begin
            peri_data = i_gpio_rdata;
        end else if (bus.user_sel[`TQV_SLOT_SCRATCH]) begin
            peri_data = i_scratch_rdata;
            peri_rdy  = i_scratch_rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= '0;
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= read_req && peri_rdy && !ready_q;   // One pulse per read
            if (!hold_q && read_req && peri_rdy) begin
                hold_q  <= 1'b1;
                rdata_q <= peri_data;
            end else if (i_read_complete) begin
                hold_q <= 1'b0;
            end
        end
    end

    assign o_rdata      = rdata_q;
    assign o_ready      = ready_q || (i_write_n != `TQV_XFER_IDLE);   // Writes complete at once
    assign o_read_block = ready_q;

endmodule

`default_nettype wire

// ==== hw/tqv_periph_defs.svh ====
// Peripheral hub constants for the slot map, register offsets and bus codes
`ifndef TQV_PERIPH_DEFS_SVH
`define TQV_PERIPH_DEFS_SVH

// Slots on each side of the address map
`define TQV_USER_SLOTS      16
`define TQV_SIMPLE_SLOTS    16

// Slot assignments
`define TQV_SLOT_GPIO       1   // Full slot
`define TQV_SLOT_SCRATCH    2   // Full slot
`define TQV_SIMPLE_SCRATCH  0   // Byte slot

// Size code when no transfer is requested
`define TQV_XFER_IDLE       2'd3

`define TQV_NUM_PINS        8

// GPIO register offsets inside its slot
`define TQV_GPIO_OUT_OFS    6'h00
`define TQV_GPIO_IN_OFS     6'h04
`define TQV_GPIO_SEL_BASE   6'h20   // One word per output pin from here

`endif

// ==== hw/tqv_periph_pkg.sv ====
// Hub package with the bus, slot and pin vector types
`default_nettype none

`include "tqv_periph_defs.svh"

package tqv_periph_pkg;

    // Core side bus
    typedef logic [10:0] bus_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  xfer_n_t;    // 0 byte, 1 half, 2 word, 3 idle

    // Slot decode
    typedef logic [$clog2(`TQV_USER_SLOTS)-1:0] slot_t;
    typedef logic [`TQV_USER_SLOTS-1:0]         slot_vec_t;
    typedef logic [5:0]                         offset_t;   // 64 bytes per full slot

    // Pin routing
    // Bit 4 picks the byte side, bits 3..0 the slot
    typedef logic [4:0]               func_sel_t;
    typedef logic [`TQV_NUM_PINS-1:0] pins_t;

endpackage

`default_nettype wire

// ==== hw/tqv_periph_top.sv ====
// Peripheral hub top level joining decode, peripherals and read return
`timescale 1ns/1ps
`default_nettype none

module tqv_periph_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  tqv_periph_pkg::pins_t     i_ui_in,
    output tqv_periph_pkg::pins_t     o_uo_out,
    input  tqv_periph_pkg::bus_addr_t i_addr,
    input  tqv_periph_pkg::word_t     i_wdata,
    input  tqv_periph_pkg::xfer_n_t   i_write_n,
    input  tqv_periph_pkg::xfer_n_t   i_read_n,
    output tqv_periph_pkg::word_t     o_rdata,
    output logic                      o_ready,
    input  logic                      i_read_complete
);
    import tqv_periph_pkg::*;

    word_t gpio_rdata;
    word_t scratch_rdata;
    logic  scratch_rdy;
    byte_t byte_rdata;
    pins_t scratch_pins;
    pins_t byte_pins;
    logic  read_block;   // Result pending at the core

    periph_bus_if u_bus ();

    bus_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_write_n    (i_write_n),
        .i_read_n     (i_read_n),
        .i_read_block (read_block),
        .bus          (u_bus)
    );

    // GPIO also owns the output pin routing
    gpio_ctrl u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus            (u_bus),
        .i_ui_in        (i_ui_in),
        .i_scratch_pins (scratch_pins),
        .i_byte_pins    (byte_pins),
        .o_rdata        (gpio_rdata),
        .o_pins         (o_uo_out)
    );

    user_scratch u_scratch (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (u_bus),
        .o_rdata (scratch_rdata),
        .o_rdy   (scratch_rdy),
        .o_pins  (scratch_pins)
    );

    byte_scratch u_byte (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (u_bus),
        .o_rdata (byte_rdata),
        .o_pins  (byte_pins)
    );

    read_return u_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus             (u_bus),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_gpio_rdata    (gpio_rdata),
        .i_scratch_rdata (scratch_rdata),
        .i_scratch_rdy   (scratch_rdy),
        .i_byte_rdata    (byte_rdata),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready),
        .o_read_block    (read_block)
    );

endmodule

`default_nettype wire

// ==== hw/user_scratch.sv ====
// Full-slot scratch peripheral with four word registers and sized writes
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defs.svh"

module user_scratch (
    input  logic                  clk,
    input  logic                  rst_n,
    periph_bus_if.target          bus,
    output tqv_periph_pkg::word_t o_rdata,
    output logic                  o_rdy,
    output tqv_periph_pkg::pins_t o_pins
);
    import tqv_periph_pkg::*;

    localparam int NUM_REGS = 4;

    word_t      regs [NUM_REGS];
    logic       sel;
    logic       reg_hit;   // Offsets 0, 4, 8 and C
    logic [1:0] idx;

    assign sel     = bus.user_sel[`TQV_SLOT_SCRATCH];
    assign reg_hit = (bus.offset[5:4] == 2'b00) && (bus.offset[1:0] == 2'b00);
    assign idx     = bus.offset[3:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (sel && reg_hit) begin
            case (bus.wr_n)
                2'd0: regs[idx][7:0]  <= bus.wdata[7:0];    // Byte
                2'd1: regs[idx][15:0] <= bus.wdata[15:0];   // Half
                2'd2: regs[idx]       <= bus.wdata;         // Word
                default: begin
                end
            endcase
        end
    end

    // Data is valid one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_rdy <= 1'b0;
        end else begin
            o_rdy <= sel && (bus.rd_n != `TQV_XFER_IDLE);
        end
    end

    assign o_rdata = reg_hit ? regs[idx] : '0;
    assign o_pins  = regs[0][`TQV_NUM_PINS-1:0];

endmodule

`default_nettype wire

// ==== sim/tb_tqv_periph.sv ====
// Hub testbench with a register model, bus stimulus and result checks
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_defs.svh"

module tb_tqv_periph;
    import tqv_periph_pkg::*;

    localparam int HALF     = 20;
    localparam int MAX_WAIT = 16;   // Cycles before a handshake counts as lost

    localparam bus_addr_t GPIO_BASE = 11'h040;   // Full slot 1
    localparam bus_addr_t SCR_BASE  = 11'h080;   // Full slot 2
    localparam bus_addr_t BYTE_BASE = 11'h400;   // Byte slot 0

    // GPIO, scratch, byte scratch, unmapped full slot 7, unmapped byte slot 3
    localparam func_sel_t ROUTES [5] = '{5'h01, 5'h02, 5'h10, 5'h07, 5'h13};

    logic      clk;
    logic      rst_n;
    pins_t     i_ui_in;
    pins_t     o_uo_out;
    bus_addr_t i_addr;
    word_t     i_wdata;
    xfer_n_t   i_write_n;
    xfer_n_t   i_read_n;
    word_t     o_rdata;
    logic      o_ready;
    logic      i_read_complete;

    // Register model
    pins_t     m_gpio_out;
    func_sel_t m_sel [`TQV_NUM_PINS];
    word_t     m_scr [4];
    byte_t     m_byte [4];

    logic [31:0] lcg_state;
    int errors       = 0;
    int checks       = 0;
    int tests        = 0;
    int tests_failed = 0;
    int errs_before  = 0;

    tqv_periph_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void model_write(bus_addr_t a, word_t d, xfer_n_t size);
        if (a[10] && a[7:4] == 4'd0 && a[3:2] == 2'b00) begin
            m_byte[a[1:0]] = d[7:0];   // Any size lands the low byte
        end else if (!a[10] && a[9:6] == 4'd1 && a[5:0] == 6'h00) begin
            m_gpio_out = d[7:0];
        end else if (!a[10] && a[9:6] == 4'd1 && a[5] && a[1:0] == 2'b00) begin
            m_sel[a[4:2]] = d[4:0];
        end else if (!a[10] && a[9:6] == 4'd2 && a[5:4] == 2'b00 && a[1:0] == 2'b00) begin
            m_scr[a[3:2]] = (size == 2'd0) ? {m_scr[a[3:2]][31:8], d[7:0]}
                          : (size == 2'd1) ? {m_scr[a[3:2]][31:16], d[15:0]} : d;
        end
    endfunction

    function automatic word_t model_read(bus_addr_t a);
        if (a[10]) begin
            return (a[7:4] == 4'd0 && a[3:2] == 2'b00) ? word_t'(m_byte[a[1:0]]) : '0;
        end
        if (a[9:6] == 4'd2) begin
            return (a[5:4] == 2'b00 && a[1:0] == 2'b00) ? m_scr[a[3:2]] : '0;
        end
        if (a[9:6] != 4'd1) begin
            return '0;   // Unmapped full slot
        end
        if (a[5:0] == 6'h00) return word_t'(m_gpio_out);
        if (a[5:0] == 6'h04) return word_t'(i_ui_in);
        return (a[5] && a[1:0] == 2'b00) ? word_t'(m_sel[a[4:2]]) : '0;
    endfunction

    function automatic pins_t model_pins();
        pins_t res;
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            case (m_sel[p])
                5'h01:   res[p] = m_gpio_out[p];
                5'h02:   res[p] = m_scr[0][p];    // Low byte of scratch register 0
                5'h10:   res[p] = m_byte[0][p];
                default: res[p] = 1'b0;
            endcase
        end
        return res;
    endfunction

    task automatic check_word(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pins(string what, pins_t got, pins_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s show %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(string name);
        tests++;
        if (errors != errs_before) tests_failed++;
        $display("Test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "errors");
        errs_before = errors;
    endtask

    // Samples a quarter period after each falling edge
    task automatic wait_ready(string what);
        int waited;
        waited = 0;
        #(HALF / 2);
        while (!o_ready && waited < MAX_WAIT) begin
            @(negedge clk);
            #(HALF / 2);
            waited++;
        end
        if (!o_ready) begin
            errors++;
            $display("The DUT never raised ready for a %s at %0d ns", what, $time);
        end
    endtask

    task automatic bus_write(bus_addr_t a, word_t d, xfer_n_t size);
        @(negedge clk);
        i_addr    = a;
        i_wdata   = d;
        i_write_n = size;
        wait_ready("write");
        @(negedge clk);
        i_write_n = `TQV_XFER_IDLE;
        model_write(a, d, size);
    endtask

    task automatic bus_read(bus_addr_t a, output word_t d);
        @(negedge clk);
        i_addr   = a;
        i_read_n = 2'd2;
        wait_ready("read");
        d = o_rdata;
        @(negedge clk);
        i_read_n        = `TQV_XFER_IDLE;
        i_read_complete = 1'b1;
        @(negedge clk);
        i_read_complete = 1'b0;
    endtask

    task automatic read_check(bus_addr_t a, string what);
        word_t got;
        bus_read(a, got);
        check_word(what, got, model_read(a));
    endtask

    initial begin
        word_t val;
        word_t held;
        int    pick;

        rst_n           = 1'b0;
        i_ui_in         = '0;
        i_addr          = '0;
        i_wdata         = '0;
        i_write_n       = `TQV_XFER_IDLE;
        i_read_n        = `TQV_XFER_IDLE;
        i_read_complete = 1'b0;
        lcg_state       = 32'hed61_1ffe;
        m_gpio_out      = '0;
        m_sel           = '{default: 5'h01};   // Every pin starts on GPIO
        m_scr           = '{default: '0};
        m_byte          = '{default: '0};
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_check(GPIO_BASE, "gpio out");
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            read_check(GPIO_BASE + bus_addr_t'(32 + 4 * p), "func select");
        end
        for (int r = 0; r < 4; r++) begin
            read_check(SCR_BASE + bus_addr_t'(4 * r), "scratch reg");
            read_check(BYTE_BASE + bus_addr_t'(r), "byte reg");
        end
        check_pins("pins", o_uo_out, model_pins());
        report_test("reset values");

        bus_write(GPIO_BASE, next_rand(), 2'd2);
        read_check(GPIO_BASE, "gpio out");
        check_pins("gpio pins", o_uo_out, model_pins());
        val     = next_rand();
        i_ui_in = val[31:24];
        read_check(GPIO_BASE + 11'd4, "gpio in");
        report_test("gpio");

        // Word first so the half and byte merges keep visible upper bits
        for (int r = 0; r < 4; r++) begin
            for (int s = 2; s >= 0; s--) begin
                bus_write(SCR_BASE + bus_addr_t'(4 * r), next_rand(), xfer_n_t'(s));
                read_check(SCR_BASE + bus_addr_t'(4 * r), "scratch sized");
            end
        end
        read_check(SCR_BASE + 11'h10, "scratch unused");
        report_test("user scratch");

        for (int r = 0; r < 4; r++) begin
            bus_write(BYTE_BASE + bus_addr_t'(r), next_rand(), 2'd2);
            read_check(BYTE_BASE + bus_addr_t'(r), "byte reg");
        end
        read_check(BYTE_BASE + 11'd8, "byte unused");
        report_test("byte scratch");

        bus_write(GPIO_BASE, next_rand(), 2'd2);
        bus_write(SCR_BASE, next_rand(), 2'd2);
        bus_write(BYTE_BASE, next_rand(), 2'd0);
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            val  = next_rand();
            pick = int'(val[31:24]) % 5;
            bus_write(GPIO_BASE + bus_addr_t'(32 + 4 * p), word_t'(ROUTES[pick]), 2'd2);
            read_check(GPIO_BASE + bus_addr_t'(32 + 4 * p), "func select");
        end
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            check_pins("routed pin", o_uo_out & pins_t'(1 << p), model_pins() & pins_t'(1 << p));
        end
        report_test("pin routing");

        bus_write(SCR_BASE, next_rand(), 2'd2);
        held = model_read(SCR_BASE);
        @(negedge clk);
        i_addr   = SCR_BASE;
        i_read_n = 2'd2;
        wait_ready("read");
        check_word("scratch read", o_rdata, held);
        @(negedge clk);
        i_addr = 11'h240;   // Unmapped full slot while the read is still pending
        @(negedge clk);
        i_read_n = `TQV_XFER_IDLE;
        check_word("held over address change", o_rdata, held);
        bus_write(SCR_BASE, ~held, 2'd2);
        check_word("held data", o_rdata, held);
        i_read_complete = 1'b1;
        @(negedge clk);
        i_read_complete = 1'b0;
        check_word("data after complete", o_rdata, held);
        read_check(11'h240, "unmapped slot 9");
        read_check(11'h000, "unmapped slot 0");
        read_check(SCR_BASE, "scratch after hold");
        report_test("read hold");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tqv_periph.f ====
+incdir+hw
hw/tqv_periph_pkg.sv
hw/periph_bus_if.sv
hw/bus_decode.sv
hw/gpio_ctrl.sv
hw/user_scratch.sv
hw/byte_scratch.sv
hw/read_return.sv
hw/tqv_periph_top.sv
sim/tb_tqv_periph.sv
